// File: source/vic_pkg.sv
`default_nettype none

package vic_pkg;

    localparam int NUM_SPRITES = 8;
    localparam int VIC_ADDR_W = 14;
    localparam int ADO_W = 12;

    // access kind of the current half, L = low half, H = high half
    typedef enum logic [3:0] {
        VIC_LP  = 4'd0,  // sprite pointer
        VIC_LS2 = 4'd1,  // sprite data, second byte
        VIC_LR  = 4'd2,  // dram refresh
        VIC_LG  = 4'd3,  // graphics
        VIC_LI  = 4'd4,
        VIC_HS1 = 4'd5,  // sprite data, first byte
        VIC_HS3 = 4'd6,  // sprite data, third byte
        VIC_HRC = 4'd7,  // c-access in refresh slot
        VIC_HGC = 4'd8,  // c-access during graphics
        VIC_HI  = 4'd9
    } vic_cycle_t;

    typedef struct packed {
        logic [2:0] cb;         // character/bitmap base
        logic [3:0] vm;         // video matrix base
        logic       bmm;
        logic       ecm;
        logic       den;
        logic [2:0] yscroll;
        logic [7:0] sprite_en;
    } vic_config_t;

    typedef struct packed {
        vic_cycle_t cycle_type;
        logic [1:0] phase;      // dot4x clock within the half
        logic [2:0] sprite_cnt;
        logic       badline;
        logic       line_start;
        logic       half_end;   // high on phase 3
        logic [7:0] refc;
        logic       frame_start; // line_start of line 0
    } vic_slot_t;

    typedef logic [VIC_ADDR_W-1:0] vic_addr_t;
    typedef logic [ADO_W-1:0] ado_t;

    typedef struct packed {
        ado_t ado;
        logic ras_n;
        logic cas_n;
        logic aec;
    } vic_bus_t;

endpackage

`default_nettype wire

// File: source/vic_cycle_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

module vic_cycle_sequencer #(
    parameter int LINE_CYCLES = 63,
    parameter int RASTER_LINES = 312
) (
    input  logic                 clk_dot4x,
    input  logic                 reset,
    output vic_pkg::vic_slot_t   slot,
    input  vic_pkg::vic_config_t cfg
);

    localparam int CYC_W = $clog2(LINE_CYCLES);
    localparam int LINE_W = $clog2(RASTER_LINES);

    logic [1:0] phase;
    logic half; // 0 low, 1 high
    logic [CYC_W-1:0] cycle;
    logic [LINE_W-1:0] line;
    logic [7:0] refc;
    logic last_cycle;
    logic last_line;
    logic badline;
    logic line_start;
    vic_pkg::vic_cycle_t cycle_type;

    assign last_cycle = (cycle == CYC_W'(LINE_CYCLES - 1));
    assign last_line = (line == LINE_W'(RASTER_LINES - 1));
    assign badline = cfg.den && (line[2:0] == cfg.yscroll);
    assign line_start = (cycle == '0) && !half && (phase == 2'd0);

    always_ff @(posedge clk_dot4x) begin
        if (reset) begin
            phase <= 2'd0;
            half <= 1'b0;
            cycle <= '0;
            line <= '0;
            refc <= 8'hff;
        end else begin
            phase <= phase + 2'd1;
            if (phase == 2'd3) begin
                half <= ~half;
                if (half) begin
                    if (last_cycle) begin
                        cycle <= '0;
                        line <= last_line ? '0 : line + 1'b1;
                    end else begin
                        cycle <= cycle + 1'b1;
                    end
                end
                if (cycle_type == vic_pkg::VIC_LR)
                    refc <= refc - 8'd1; // counts down once per refresh
            end
        end
    end

    // per-line schedule, sprite fetch first
    always_comb begin
        if (cycle < CYC_W'(16)) begin
            if (!cycle[0])
                cycle_type = half ? vic_pkg::VIC_HS1 : vic_pkg::VIC_LP;
            else
                cycle_type = half ? vic_pkg::VIC_HS3 : vic_pkg::VIC_LS2;
        end else if (cycle < CYC_W'(21)) begin
            if (!half)
                cycle_type = vic_pkg::VIC_LR;
            else if (badline && cycle == CYC_W'(20))
                cycle_type = vic_pkg::VIC_HRC;
            else
                cycle_type = vic_pkg::VIC_HI;
        end else if (cycle < CYC_W'(61)) begin
            if (!half)
                cycle_type = vic_pkg::VIC_LG;
            else
                cycle_type = badline ? vic_pkg::VIC_HGC : vic_pkg::VIC_HI;
        end else begin
            cycle_type = half ? vic_pkg::VIC_HI : vic_pkg::VIC_LI;
        end
    end

    always_comb begin
        slot.cycle_type = cycle_type;
        slot.phase = phase;
        slot.sprite_cnt = cycle[3:1]; // two cycles per sprite
        slot.badline = badline;
        slot.line_start = line_start;
        slot.half_end = (phase == 2'd3);
        slot.refc = refc;
        slot.frame_start = line_start && (line == '0);
    end

endmodule

`default_nettype wire

// File: source/vic_video_counter.sv
`timescale 1ns/10ps
`default_nettype none

module vic_video_counter (
    input  logic                 clk_dot4x,
    input  logic                 reset,
    input  vic_pkg::vic_slot_t   slot,
    input  vic_pkg::vic_config_t cfg,
    input  logic [7:0]           db,
    output logic [9:0]           vc,
    output logic [2:0]           rc,
    output logic                 idle,
    output logic [7:0]           char_ptr
);

    logic [9:0] vcbase;
    logic g_end;
    logic c_end;

    assign g_end = slot.half_end && (slot.cycle_type == vic_pkg::VIC_LG);
    assign c_end = slot.half_end && (slot.cycle_type == vic_pkg::VIC_HGC);

    always_ff @(posedge clk_dot4x) begin
        if (reset) begin
            vc <= 10'd0;
            vcbase <= 10'd0;
            rc <= 3'd0;
            idle <= 1'b1;
        end else begin
            if (slot.frame_start) begin
                vcbase <= 10'd0;
                vc <= 10'd0;
            end else if (slot.line_start) begin
                // end of a character row, move the base on
                if (!idle && rc == 3'd7)
                    vcbase <= vc;
                else
                    vc <= vcbase;
            end else if (g_end && !idle) begin
                vc <= vc + 10'd1;
            end

            if (slot.line_start) begin
                if (slot.badline) begin
                    rc <= 3'd0;
                    idle <= 1'b0;
                end else if (!cfg.den) begin
                    idle <= 1'b1;
                end else if (!idle) begin
                    rc <= rc + 3'd1; // wraps 7 -> 0
                end
            end
        end
    end

    // screen code from the c-access
    always_ff @(posedge clk_dot4x) begin
        if (c_end)
            char_ptr <= db;
    end

endmodule

`default_nettype wire

// File: source/vic_sprite_fetch.sv
`timescale 1ns/10ps
`default_nettype none

module vic_sprite_fetch (
    input  logic                 clk_dot4x,
    input  logic                 reset,
    input  vic_pkg::vic_slot_t   slot,
    input  vic_pkg::vic_config_t cfg,
    input  logic [7:0]           db,
    input  logic                 cpu_bus_write,
    output logic [7:0]           sprite_ptr [vic_pkg::NUM_SPRITES],
    output logic [5:0]           sprite_mc [vic_pkg::NUM_SPRITES]
);

    logic p_end;
    logic s_end;

    assign p_end = slot.half_end && (slot.cycle_type == vic_pkg::VIC_LP);
    assign s_end = slot.half_end && (slot.cycle_type inside
        {vic_pkg::VIC_HS1, vic_pkg::VIC_LS2, vic_pkg::VIC_HS3});

    always_ff @(posedge clk_dot4x) begin
        if (p_end)
            sprite_ptr[slot.sprite_cnt] <= db;
    end

    // data counters, one byte per s-access
    always_ff @(posedge clk_dot4x) begin
        if (reset) begin
            for (int i = 0; i < vic_pkg::NUM_SPRITES; i++)
                sprite_mc[i] <= 6'd0;
        end else if (slot.frame_start) begin
            for (int i = 0; i < vic_pkg::NUM_SPRITES; i++)
                sprite_mc[i] <= 6'd0;
        end else if (s_end && cfg.sprite_en[slot.sprite_cnt] && !cpu_bus_write) begin
            if (sprite_mc[slot.sprite_cnt] == 6'd62)
                sprite_mc[slot.sprite_cnt] <= 6'd0; // 63 bytes per sprite
            else
                sprite_mc[slot.sprite_cnt] <= sprite_mc[slot.sprite_cnt] + 6'd1;
        end
    end

endmodule

`default_nettype wire

// File: source/vic_addressgen.sv
`timescale 1ns/10ps
`default_nettype none

module vic_addressgen (
    input  logic                 clk_dot4x,
    input  vic_pkg::vic_slot_t   slot,
    input  vic_pkg::vic_config_t cfg,
    input  logic [9:0]           vc,
    input  logic [2:0]           rc,
    input  logic                 idle,
    input  logic [7:0]           char_ptr,
    input  logic                 cpu_bus_write,
    input  logic [7:0]           sprite_ptr [vic_pkg::NUM_SPRITES],
    input  logic [5:0]           sprite_mc [vic_pkg::NUM_SPRITES],
    output vic_pkg::ado_t        ado
);

    vic_pkg::vic_addr_t vic_addr;
    vic_pkg::vic_addr_t idle_addr;
    logic mux; // 0 row, 1 column
    logic [7:0] ado8;

    assign idle_addr = cfg.ecm ? 14'h39ff : 14'h3fff;
    assign mux = slot.phase[1];

    always_comb begin
        case (slot.cycle_type)
            vic_pkg::VIC_LR:
                vic_addr = {6'b111111, slot.refc};
            vic_pkg::VIC_LG: begin
                if (idle) begin
                    vic_addr = idle_addr;
                end else begin
                    if (cfg.bmm)
                        vic_addr = {cfg.cb[2], vc, rc};
                    else
                        vic_addr = {cfg.cb, char_ptr, rc};
                    if (cfg.ecm)
                        vic_addr[10:9] = 2'b00;
                end
            end
            vic_pkg::VIC_HRC, vic_pkg::VIC_HGC:
                vic_addr = {cfg.vm, vc}; // matrix read
            vic_pkg::VIC_LP:
                vic_addr = {cfg.vm, 7'b1111111, slot.sprite_cnt};
            vic_pkg::VIC_HS1, vic_pkg::VIC_LS2, vic_pkg::VIC_HS3: begin
                // cpu owns the bus on a write
                if (cpu_bus_write)
                    vic_addr = idle_addr;
                else
                    vic_addr = {sprite_ptr[slot.sprite_cnt], sprite_mc[slot.sprite_cnt]};
            end
            default:
                vic_addr = 14'h3fff;
        endcase
    end

    // row goes out first, then column
    always_ff @(posedge clk_dot4x) begin
        ado8 <= mux ? vic_addr[7:0] : {2'b11, vic_addr[13:8]};
    end

    assign ado = {vic_addr[11:8], ado8};

endmodule

`default_nettype wire

// File: source/vic_dram_strobes.sv
`timescale 1ns/10ps
`default_nettype none

module vic_dram_strobes (
    input  logic               clk_dot4x,
    input  logic               reset,
    input  vic_pkg::vic_slot_t slot,
    output logic               ras_n,
    output logic               cas_n,
    output logic               aec
);

    logic idle_half;
    logic low_half;
    logic high_access;

    assign idle_half = slot.cycle_type inside {vic_pkg::VIC_LI, vic_pkg::VIC_HI};
    assign low_half = slot.cycle_type inside
        {vic_pkg::VIC_LP, vic_pkg::VIC_LS2, vic_pkg::VIC_LR, vic_pkg::VIC_LG, vic_pkg::VIC_LI};
    assign high_access = slot.cycle_type inside
        {vic_pkg::VIC_HGC, vic_pkg::VIC_HRC, vic_pkg::VIC_HS1, vic_pkg::VIC_HS3};

    // one clock behind the phase, like the address mux
    always_ff @(posedge clk_dot4x) begin
        if (reset) begin
            ras_n <= 1'b1;
            cas_n <= 1'b1;
            aec <= 1'b0;
        end else begin
            ras_n <= idle_half || (slot.phase == 2'd3); // low in phases 1..3
            cas_n <= idle_half || (slot.phase != 2'd2); // low in phase 3 only
            aec <= low_half || high_access;
        end
    end

endmodule

`default_nettype wire

// File: source/vic_memory_access.sv
`timescale 1ns/10ps
`default_nettype none

module vic_memory_access #(
    parameter int LINE_CYCLES = 63,
    parameter int RASTER_LINES = 312
) (
    input  logic                 clk_dot4x,
    input  logic                 reset,
    input  vic_pkg::vic_config_t cfg,
    input  logic [7:0]           db,
    input  logic                 cpu_bus_write,
    output vic_pkg::vic_bus_t    bus
);

    vic_pkg::vic_slot_t slot;
    logic [9:0] vc;
    logic [2:0] rc;
    logic idle;
    logic [7:0] char_ptr;
    logic [7:0] sprite_ptr [vic_pkg::NUM_SPRITES];
    logic [5:0] sprite_mc [vic_pkg::NUM_SPRITES];
    vic_pkg::ado_t ado;
    logic ras_n;
    logic cas_n;
    logic aec;

    vic_cycle_sequencer #(
        .LINE_CYCLES  (LINE_CYCLES),
        .RASTER_LINES (RASTER_LINES)
    ) i_cycle_sequencer (
        .clk_dot4x (clk_dot4x),
        .reset     (reset),
        .slot      (slot),
        .cfg       (cfg)
    );

    vic_video_counter i_video_counter (
        .clk_dot4x (clk_dot4x),
        .reset     (reset),
        .slot      (slot),
        .cfg       (cfg),
        .db        (db),
        .vc        (vc),
        .rc        (rc),
        .idle      (idle),
        .char_ptr  (char_ptr)
    );

    vic_sprite_fetch i_sprite_fetch (
        .clk_dot4x     (clk_dot4x),
        .reset         (reset),
        .slot          (slot),
        .cfg           (cfg),
        .db            (db),
        .cpu_bus_write (cpu_bus_write),
        .sprite_ptr    (sprite_ptr),
        .sprite_mc     (sprite_mc)
    );

    vic_addressgen i_addressgen (
        .clk_dot4x     (clk_dot4x),
        .slot          (slot),
        .cfg           (cfg),
        .vc            (vc),
        .rc            (rc),
        .idle          (idle),
        .char_ptr      (char_ptr),
        .cpu_bus_write (cpu_bus_write),
        .sprite_ptr    (sprite_ptr),
        .sprite_mc     (sprite_mc),
        .ado           (ado)
    );

    vic_dram_strobes i_dram_strobes (
        .clk_dot4x (clk_dot4x),
        .reset     (reset),
        .slot      (slot),
        .ras_n     (ras_n),
        .cas_n     (cas_n),
        .aec       (aec)
    );

    assign bus = '{ado: ado, ras_n: ras_n, cas_n: cas_n, aec: aec};

endmodule

`default_nettype wire

// File: verif/vic_memory_access_properties.sv
`timescale 1ns/10ps
`default_nettype none

module vic_memory_access_properties (
    input  logic               clk_dot4x,
    input  logic               reset,
    input  vic_pkg::vic_slot_t slot,
    input  logic               ras_n,
    input  logic               cas_n,
    input  logic               aec
);

    int unsigned assert_failures = 0;

    // cas only inside an open row
    cas_inside_ras: assert property (@(posedge clk_dot4x) disable iff (reset)
        !cas_n |-> !ras_n)
        else begin
            $error("cas_n low while ras_n high");
            assert_failures++;
        end

    reset_strobes_high: assert property (@(posedge clk_dot4x)
        reset |=> (ras_n && cas_n && !aec))
        else begin
            $error("strobes not idle in the clock after reset");
            assert_failures++;
        end

    // strobes lag the slot by one clock
    idle_half_quiet: assert property (@(posedge clk_dot4x) disable iff (reset)
        (slot.cycle_type == vic_pkg::VIC_LI || slot.cycle_type == vic_pkg::VIC_HI)
        |=> (ras_n && cas_n))
        else begin
            $error("dram strobe active in an idle half");
            assert_failures++;
        end

endmodule

bind vic_dram_strobes vic_memory_access_properties i_strobe_props (
    .clk_dot4x (clk_dot4x),
    .reset     (reset),
    .slot      (slot),
    .ras_n     (ras_n),
    .cas_n     (cas_n),
    .aec       (aec)
);

`default_nettype wire

// File: verif/vic_memory_access_tb.sv
`timescale 1ns/10ps
`default_nettype none

module vic_memory_access_tb;

    localparam int LINE_CYCLES = 63;
    localparam int CLOCKS_PER_LINE = LINE_CYCLES * 8; // two halves of four phases

    typedef struct {
        string                name;
        vic_pkg::vic_config_t cfg;
        logic [7:0]           db;
        logic                 cpu_bus_write;
        int                   line;
        int                   cycle;
        int                   half;
        vic_pkg::vic_cycle_t  kind;
        vic_pkg::vic_addr_t   addr;
    } stim_row_t;

    logic clk_dot4x;
    logic reset;
    vic_pkg::vic_config_t cfg;
    logic [7:0] db;
    logic cpu_bus_write;
    vic_pkg::vic_bus_t bus;

    stim_row_t rows[$];
    logic [31:0] lfsr;
    int state_idx;   // clocks since reset release
    int err_count;
    int last_clock;
    bit table_ready;

    vic_memory_access #(
        .LINE_CYCLES  (LINE_CYCLES),
        .RASTER_LINES (16)
    ) i_vic_memory_access (
        .clk_dot4x     (clk_dot4x),
        .reset         (reset),
        .cfg           (cfg),
        .db            (db),
        .cpu_bus_write (cpu_bus_write),
        .bus           (bus)
    );

    initial begin
        clk_dot4x = 1'b0;
        forever #50 clk_dot4x = ~clk_dot4x;
    end

    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    task automatic random_byte(output logic [7:0] b);
        b = 8'h00;
        for (int i = 0; i < 8; i++) begin
            b = {b[6:0], lfsr[0]};
            lfsr = lfsr_next(lfsr); // one step per bit
        end
    endtask

    function automatic vic_pkg::ado_t row_of(vic_pkg::vic_addr_t a);
        return {a[11:8], 2'b11, a[13:8]};
    endfunction

    function automatic vic_pkg::ado_t col_of(vic_pkg::vic_addr_t a);
        return {a[11:8], a[7:0]};
    endfunction

    // g-access address in display state
    function automatic vic_pkg::vic_addr_t gfx_addr(vic_pkg::vic_config_t c, logic [9:0] vc,
                                                     logic [7:0] ptr, logic [2:0] rc);
        vic_pkg::vic_addr_t a;
        a = c.bmm ? {c.cb[2], vc, rc} : {c.cb, ptr, rc};
        if (c.ecm)
            a[10:9] = 2'b00;
        return a;
    endfunction

    function automatic vic_pkg::vic_bus_t strobes_for(vic_pkg::vic_cycle_t kind, int phase);
        vic_pkg::vic_bus_t b;
        b = '0;
        b.aec = (kind != vic_pkg::VIC_HI); // every low half plus the active high halves
        if (kind == vic_pkg::VIC_LI || kind == vic_pkg::VIC_HI) begin
            b.ras_n = 1'b1;
            b.cas_n = 1'b1;
        end else begin
            b.ras_n = 1'b0;
            b.cas_n = (phase != 3);
        end
        return b;
    endfunction

    task automatic compare_ado(string name, vic_pkg::ado_t exp, vic_pkg::ado_t act);
        if (act !== exp) begin
            err_count++;
            $display("FAIL %s: ado expected %h, actual %h", name, exp, act);
            $display("test failed");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic compare_strobes(string name, vic_pkg::vic_bus_t exp, vic_pkg::vic_bus_t act);
        if ({act.ras_n, act.cas_n, act.aec} !== {exp.ras_n, exp.cas_n, exp.aec}) begin
            err_count++;
            $display("FAIL %s: ras_n/cas_n/aec expected %b%b%b, actual %b%b%b", name,
                     exp.ras_n, exp.cas_n, exp.aec, act.ras_n, act.cas_n, act.aec);
            $display("test failed");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic add_row(string name, vic_pkg::vic_config_t c, logic [7:0] d, logic wr,
                           int line, int cycle, int half, vic_pkg::vic_cycle_t kind,
                           vic_pkg::vic_addr_t addr);
        rows.push_back('{name, c, d, wr, line, cycle, half, kind, addr});
        last_clock = line * CLOCKS_PER_LINE + (cycle * 2 + half) * 4 + 3;
    endtask

    task automatic build_table();
        vic_pkg::vic_config_t c;
        logic [7:0] d;
        c = '{cb: 3'b010, vm: 4'h1, bmm: 1'b0, ecm: 1'b0, den: 1'b0,
              yscroll: 3'd0, sprite_en: 8'h00};
        for (int i = 0; i < 5; i++)
            add_row($sformatf("refresh_%0d", 16 + i), c, 8'h00, 1'b0, 0, 16 + i, 0,
                    vic_pkg::VIC_LR, {6'h3f, 8'(255 - i)});
        add_row("idle_g", c, 8'h00, 1'b0, 0, 21, 0, vic_pkg::VIC_LG, 14'h3fff);
        add_row("idle_hi", c, 8'h00, 1'b0, 0, 21, 1, vic_pkg::VIC_HI, 14'h3fff);
        c.ecm = 1'b1;
        add_row("idle_g_ecm", c, 8'h00, 1'b0, 1, 30, 0, vic_pkg::VIC_LG, 14'h39ff);
        // badline on line 2, vc starts from 0
        c = '{cb: 3'b011, vm: 4'h5, bmm: 1'b0, ecm: 1'b0, den: 1'b1,
              yscroll: 3'd2, sprite_en: 8'h00};
        random_byte(d);
        add_row("c_hrc", c, 8'h00, 1'b0, 2, 20, 1, vic_pkg::VIC_HRC, {c.vm, 10'd0});
        add_row("c_hgc", c, d, 1'b0, 2, 21, 1, vic_pkg::VIC_HGC, {c.vm, 10'd1});
        add_row("g_char", c, 8'h00, 1'b0, 2, 22, 0, vic_pkg::VIC_LG,
                gfx_addr(c, 10'd0, d, 3'd0));
        c.bmm = 1'b1;
        c.cb = 3'b101;
        add_row("g_bitmap", c, 8'h00, 1'b0, 3, 23, 0, vic_pkg::VIC_LG,
                gfx_addr(c, 10'd2, 8'h00, 3'd1));
        // sprites 3 and 5 on line 4
        c = '{cb: 3'b101, vm: 4'h5, bmm: 1'b0, ecm: 1'b0, den: 1'b0,
              yscroll: 3'd2, sprite_en: 8'h28};
        random_byte(d);
        add_row("p_spr3", c, d, 1'b0, 4, 6, 0, vic_pkg::VIC_LP, {c.vm, 7'h7f, 3'd3});
        add_row("s_spr3_0", c, 8'h00, 1'b0, 4, 6, 1, vic_pkg::VIC_HS1, {d, 6'd0});
        add_row("s_spr3_1", c, 8'h00, 1'b0, 4, 7, 0, vic_pkg::VIC_LS2, {d, 6'd1});
        add_row("s_spr3_2", c, 8'h00, 1'b0, 4, 7, 1, vic_pkg::VIC_HS3, {d, 6'd2});
        random_byte(d);
        add_row("p_spr5", c, d, 1'b0, 4, 10, 0, vic_pkg::VIC_LP, {c.vm, 7'h7f, 3'd5});
        add_row("s_spr5_cpu", c, 8'h00, 1'b1, 4, 10, 1, vic_pkg::VIC_HS1, 14'h3fff);
        add_row("s_spr5_0", c, 8'h00, 1'b0, 4, 11, 0, vic_pkg::VIC_LS2, {d, 6'd0});
        add_row("li_idle", c, 8'h00, 1'b0, 4, 61, 0, vic_pkg::VIC_LI, 14'h3fff);
        // second badline, extended colour mode
        c = '{cb: 3'b110, vm: 4'h9, bmm: 1'b0, ecm: 1'b1, den: 1'b1,
              yscroll: 3'd2, sprite_en: 8'h00};
        random_byte(d);
        d = d | 8'hc0; // bits 7:6 land on addr 10:9
        add_row("c_hgc_ecm", c, d, 1'b0, 10, 21, 1, vic_pkg::VIC_HGC, {c.vm, 10'd1});
        add_row("g_char_ecm", c, 8'h00, 1'b0, 10, 22, 0, vic_pkg::VIC_LG,
                gfx_addr(c, 10'd0, d, 3'd0));
    endtask

    task automatic goto_state(int n);
        while (state_idx < n) begin
            @(posedge clk_dot4x);
            #5;
            state_idx++;
        end
    endtask

    // row sampled in phase 2, column in phase 3
    task automatic check_half(stim_row_t r, int base);
        goto_state(base + 2);
        @(negedge clk_dot4x);
        compare_ado({r.name, " row"}, row_of(r.addr), bus.ado);
        compare_strobes({r.name, " phase 2"}, strobes_for(r.kind, 2), bus);
        goto_state(base + 3);
        @(negedge clk_dot4x);
        compare_ado({r.name, " column"}, col_of(r.addr), bus.ado);
        compare_strobes({r.name, " phase 3"}, strobes_for(r.kind, 3), bus);
    endtask

    initial begin
        int line_base;
        int half_base;
        reset = 1'b1;
        cfg = '0;
        db = 8'h00;
        cpu_bus_write = 1'b0;
        lfsr = 32'h8a2ed252;
        err_count = 0;
        state_idx = 0;
        build_table();
        table_ready = 1'b1;
        repeat (2) @(posedge clk_dot4x);
        #5;
        reset = 1'b0; // now in line 0, cycle 0, phase 0
        foreach (rows[i]) begin
            line_base = rows[i].line * CLOCKS_PER_LINE;
            half_base = line_base + (rows[i].cycle * 2 + rows[i].half) * 4;
            if (state_idx <= line_base) begin
                goto_state(line_base);
                cfg = rows[i].cfg; // config only moves at a line start
            end
            goto_state(half_base);
            db = rows[i].db;
            cpu_bus_write = rows[i].cpu_bus_write;
            check_half(rows[i], half_base);
        end
        goto_state(state_idx + 8);
        if (err_count == 0 &&
            i_vic_memory_access.i_dram_strobes.i_strobe_props.assert_failures == 0) begin
            $display("test passed");
            $finish;
        end else begin
            $display("test failed");
            $fatal(1, "assertion failures seen in the strobe checks");
        end
    end

    // a failed strobe assertion ends the run at once
    initial begin
        wait (i_vic_memory_access.i_dram_strobes.i_strobe_props.assert_failures != 0);
        $display("strobe assertion failed at %0t", $time);
        $display("test failed");
        $fatal(1, "strobe assertion failed");
    end

    initial begin
        wait (table_ready);
        repeat (last_clock + 1000) @(posedge clk_dot4x);
        $display("timeout: no result within %0d clocks", last_clock + 1000);
        $display("test failed");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

// File: files.f
source/vic_pkg.sv
source/vic_cycle_sequencer.sv
source/vic_video_counter.sv
source/vic_sprite_fetch.sv
source/vic_addressgen.sv
source/vic_dram_strobes.sv
source/vic_memory_access.sv
verif/vic_memory_access_properties.sv
verif/vic_memory_access_tb.sv
